// ==== flist.f ====
design/cachePkg.sv
design/tagStore.sv
design/lineStore.sv
design/transBuffer.sv
design/cacheCtrl.sv
design/dataCacheTop.sv
test/cacheCtrl_properties.sv
test/dataCacheTb.sv

// ==== test/dataCacheTb.sv ====
`timescale 1ns/10ps

module dataCacheTb;

  localparam int          TLB_N = 4;
  localparam logic [19:0] VPN0  = 20'h12340; // Pages VPN0 and VPN0+1
  localparam logic [19:0] PPN0  = 20'h00a60;

  logic                 clk;
  logic                 rst;
  logic                 reqStrobe;
  logic                 busy;
  logic                 done;
  logic                 tlbWrite;
  logic                 memReadReq;
  logic                 memWriteReq;
  logic                 memFill;
  logic [31:0]          memAddr;
  cachePkg::cacheReq_t  req;
  cachePkg::cacheResp_t resp;
  cachePkg::tlbEntry_t  tlbEntry;
  cachePkg::line_t      memWriteLine;
  cachePkg::line_t      memLine;

  logic [31:0]      lfsr = 32'h3c52_c14e;
  logic [7:0]       refMem [8192];  // Bytes as the CPU sees them
  logic [7:0]       backMem [8192]; // Bytes held by memory
  logic [1023:0]    dirtyLine;      // Written since fill
  logic [1023:0]    touched;
  logic [19:0]      tlbVpn [TLB_N];
  logic [TLB_N-1:0] tlbValid;
  int               tlbPtr;

  dataCacheTop #(.TLB_ENTRIES(TLB_N)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // Galois step
    end
    return v;
  endfunction

  function automatic cachePkg::line_t lineOf(input logic fromBack, input logic [9:0] ln);
    cachePkg::line_t l;
    for (int k = 0; k < 8; k++) begin
      l[k] = fromBack ? backMem[{ln, 3'(k)}] : refMem[{ln, 3'(k)}];
    end
    return l;
  endfunction

  task automatic stopWithFail();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      stopWithFail();
    end
  endtask

  always @(negedge clk) begin
    if (u_dut.u_ctrl.u_props.errorCount != 0) begin
      $display("A controller assertion failed");
      stopWithFail();
    end
  end

  task automatic mapPage(input logic [19:0] vpn, input logic [19:0] ppn);
    @(negedge clk);
    tlbWrite = 1'b1;
    tlbEntry = '{vpn: vpn, ppn: ppn};
    @(negedge clk);
    tlbWrite         = 1'b0;
    tlbVpn[tlbPtr]   = vpn;
    tlbValid[tlbPtr] = 1'b1;
    tlbPtr           = (tlbPtr + 1) % TLB_N; // Round-robin slot
  endtask

  task automatic access(input logic write, input logic word, input logic [31:0] va,
                        input logic [31:0] wd);
    logic [12:0] a;
    logic        mapped;
    logic        expFault;
    logic        rdSeen;
    logic        wbSeen;
    logic [31:0] expLoad;
    int          cycles;
    int          fillCnt;
    a      = va[12:0]; // Physical page bit follows virtual page bit
    mapped = 1'b0;
    for (int i = 0; i < TLB_N; i++) begin
      mapped = mapped | (tlbValid[i] && tlbVpn[i] == va[31:12]);
    end
    expFault = !mapped || (word && a[1:0] != 2'b00);
    expLoad  = word ? {refMem[a+3], refMem[a+2], refMem[a+1], refMem[a]}
                    : {{24{refMem[a][7]}}, refMem[a]};
    @(negedge clk);
    reqStrobe = 1'b1;
    req       = '{write: write, word: word, vaddr: va, wdata: wd};
    @(negedge clk);
    reqStrobe = 1'b0;
    checkEq("busy", busy, 1'b1);
    cycles  = 1;
    rdSeen  = 1'b0;
    wbSeen  = 1'b0;
    fillCnt = 0;
    do begin
      @(negedge clk);
      cycles++;
      memFill = 1'b0;
      if (cycles > 40) begin
        $display("Timeout: no done for the access to %h", va);
        stopWithFail();
      end
      if (memWriteReq) begin
        checkEq("dirty flag of written-back line", dirtyLine[memAddr[12:3]], 1'b1);
        checkEq("memAddr page", memAddr[31:13], PPN0[19:1]);
        checkEq("memWriteLine", memWriteLine, lineOf(1'b0, memAddr[12:3]));
        for (int k = 0; k < 8; k++) begin
          backMem[{memAddr[12:3], 3'(k)}] = memWriteLine[k];
        end
        dirtyLine[memAddr[12:3]] = 1'b0;
        wbSeen = 1'b1;
      end
      if (memReadReq) begin
        checkEq("memReadReq cycle", cycles, wbSeen ? 3 : 2);
        checkEq("memAddr", memAddr, {PPN0[19:1], a[12:3], 3'b000});
        rdSeen  = 1'b1;
        fillCnt = 1 + int'(takeBits(3)); // 1 to 8 cycles
      end else if (fillCnt > 0) begin
        fillCnt--;
        if (fillCnt == 0) begin
          memFill = 1'b1;
          memLine = lineOf(1'b1, a[12:3]);
        end
      end
    end while (!done);
    checkEq("busy", busy, 1'b0);
    checkEq("resp.fault", resp.fault, expFault);
    if (expFault) checkEq("memory strobes of faulted access", {rdSeen, wbSeen}, 2'b00);
    if (!rdSeen) checkEq("done latency", cycles, 2);
    if (!expFault && !touched[a[12:3]]) checkEq("refill on first access", rdSeen, 1'b1);
    if (!expFault && !write) checkEq("resp.loadData", resp.loadData, expLoad);
    if (!expFault) begin
      touched[a[12:3]] = 1'b1;
      if (write) begin
        dirtyLine[a[12:3]] = 1'b1;
        for (int k = 0; k < (word ? 4 : 1); k++) begin
          refMem[a + k] = wd[8*k +: 8]; // Little-endian
        end
      end
    end
  endtask

  task automatic randomOps(input int count);
    logic [31:0] va;
    logic        word;
    logic        write;
    for (int n = 0; n < count; n++) begin
      va    = {VPN0, 12'h000} | (takeBits(1) << 12);
      va    = va | (takeBits(2) << 8) | takeBits(6); // Tag bits, low index, offset
      word  = 1'(takeBits(1));
      if (word && takeBits(2) != 0) va[1:0] = 2'b00; // Mostly aligned words
      write = 1'(takeBits(1));
      access(write, word, va, takeBits(32));
      if (write) begin
        access(1'b0, 1'b0, va, '0);
        access(1'b0, 1'b1, va & ~32'h3, '0);
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    reqStrobe = 1'b0;
    req       = '0;
    tlbWrite  = 1'b0;
    tlbEntry  = '0;
    memFill   = 1'b0;
    memLine   = '0;
    dirtyLine = '0;
    touched   = '0;
    tlbValid  = '0;
    tlbPtr    = 0;
    for (int i = 0; i < 8192; i++) begin
      refMem[i]  = 8'((i * 37) ^ (i >> 5));
      backMem[i] = refMem[i];
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    checkEq("busy/done/memReadReq/memWriteReq", {busy, done, memReadReq, memWriteReq}, 4'b0);

    access(1'b0, 1'b0, {VPN0, 12'h010}, '0); // TLB still empty
    access(1'b1, 1'b1, {VPN0 | 20'h1, 12'h020}, 32'hdead_beef);
    mapPage(VPN0, PPN0);
    mapPage(VPN0 | 20'h1, PPN0 | 20'h1);
    access(1'b0, 1'b0, {VPN0, 12'h010}, '0);
    access(1'b1, 1'b1, {VPN0 | 20'h1, 12'h020}, 32'hdead_beef);
    randomOps(300);

    for (int k = 0; k < TLB_N - 1; k++) begin
      mapPage(20'hfff00 + 20'(k), 20'h00001); // Pushes page 0 out
    end
    access(1'b0, 1'b1, {VPN0, 12'h040}, '0);
    access(1'b0, 1'b1, {VPN0 | 20'h1, 12'h040}, '0);
    mapPage(VPN0, PPN0); // Lands on the slot of page 1
    access(1'b0, 1'b1, {VPN0, 12'h040}, '0);
    access(1'b0, 1'b1, {VPN0 | 20'h1, 12'h040}, '0);
    mapPage(VPN0 | 20'h1, PPN0 | 20'h1);
    access(1'b0, 1'b1, {VPN0 | 20'h1, 12'h040}, '0);
    randomOps(100);

    checkEq("assertion failures", u_dut.u_ctrl.u_props.errorCount, 0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== test/cacheCtrl_properties.sv ====
`timescale 1ns/10ps

module cacheCtrl_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 busy,
  input logic                 done,
  input cachePkg::cacheResp_t resp,
  input logic                 memReadReq,
  input logic                 memWriteReq,
  input logic                 memFill
);

  int   errorCount = 0;
  logic strobeInReq; // Memory traffic in the current request
  logic fillPending;

  always_ff @(posedge clk) begin
    if (rst || done) begin
      strobeInReq <= 1'b0;
    end else if (memReadReq || memWriteReq) begin
      strobeInReq <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || memFill) begin
      fillPending <= 1'b0;
    end else if (memReadReq) begin
      fillPending <= 1'b1;
    end
  end

  doneAfterBusy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
    else begin
      $error("done without busy in the previous cycle");
      errorCount++;
    end

  oneMemStrobe: assert property (@(posedge clk) disable iff (rst) !(memReadReq && memWriteReq))
    else begin
      $error("memReadReq and memWriteReq together");
      errorCount++;
    end

  faultNoTraffic: assert property (@(posedge clk) disable iff (rst)
    (done && resp.fault) |-> !strobeInReq)
    else begin
      $error("faulted request issued a memory strobe");
      errorCount++;
    end

  fillBeforeDone: assert property (@(posedge clk) disable iff (rst) done |-> !fillPending)
    else begin
      $error("done while a memory read is unanswered");
      errorCount++;
    end

endmodule

bind cacheCtrl cacheCtrl_properties u_props (
  .clk, .rst, .busy, .done, .resp, .memReadReq, .memWriteReq, .memFill
);

// ==== design/dataCacheTop.sv ====
`timescale 1ns/10ps

module dataCacheTop #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 reqStrobe,
  input  cachePkg::cacheReq_t  req,
  output logic                 busy,
  output logic                 done,
  output cachePkg::cacheResp_t resp,
  input  logic                 tlbWrite,
  input  cachePkg::tlbEntry_t  tlbEntry,
  output logic                 memReadReq,
  output logic                 memWriteReq,
  output logic [31:0]          memAddr,
  output cachePkg::line_t      memWriteLine,
  input  logic                 memFill,
  input  cachePkg::line_t      memLine
);

  logic [cachePkg::VPN_BITS-1:0] vpn;
  logic [cachePkg::PPN_BITS-1:0] ppn;
  logic                          tlbMiss;
  logic [cachePkg::IDX_BITS-1:0] idx;
  logic [cachePkg::TAG_BITS-1:0] tag;
  logic [cachePkg::TAG_BITS-1:0] victimTag;
  logic [cachePkg::OFF_BITS-1:0] byteOff;
  logic                          word;
  logic [31:0]                   wdata;
  logic [31:0]                   loadData;
  logic                          hit;
  logic                          dirty;
  logic                          storeWrite;
  logic                          lineFill;
  logic                          tagFill;
  logic                          markDirty;
  cachePkg::line_t               fillLine;
  cachePkg::line_t               line;

  cacheCtrl u_ctrl (
    .clk, .rst, .reqStrobe, .req, .busy, .done, .resp,
    .ppn, .tlbMiss, .hit, .dirty, .victimTag, .loadData, .line,
    .memFill, .memLine, .vpn, .idx, .tag, .byteOff, .word, .wdata,
    .storeWrite, .lineFill, .tagFill, .markDirty, .fillLine,
    .memReadReq, .memWriteReq, .memAddr, .memWriteLine
  );

  tagStore u_tags (
    .clk, .rst, .idx, .tag, .fill(tagFill), .markDirty,
    .hit, .dirty, .victimTag
  );

  lineStore u_lines (
    .clk, .idx, .byteOff, .word, .write(storeWrite), .fill(lineFill),
    .wdata, .fillLine, .line, .loadData
  );

  transBuffer #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) u_tlb (
    .clk, .rst, .vpn, .ppn, .tlbMiss, .tlbWrite, .tlbEntry
  );

endmodule

// ==== design/cacheCtrl.sv ====
`timescale 1ns/10ps

module cacheCtrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          reqStrobe,
  input  cachePkg::cacheReq_t           req,
  output logic                          busy,
  output logic                          done,
  output cachePkg::cacheResp_t          resp,
  input  logic [cachePkg::PPN_BITS-1:0] ppn,
  input  logic                          tlbMiss,
  input  logic                          hit,
  input  logic                          dirty,
  input  logic [cachePkg::TAG_BITS-1:0] victimTag,
  input  logic [31:0]                   loadData,
  input  cachePkg::line_t               line,
  input  logic                          memFill,
  input  cachePkg::line_t               memLine,
  output logic [cachePkg::VPN_BITS-1:0] vpn,
  output logic [cachePkg::IDX_BITS-1:0] idx,
  output logic [cachePkg::TAG_BITS-1:0] tag,
  output logic [cachePkg::OFF_BITS-1:0] byteOff,
  output logic                          word,
  output logic [31:0]                   wdata,
  output logic                          storeWrite,
  output logic                          lineFill,
  output logic                          tagFill,
  output logic                          markDirty,
  output cachePkg::line_t               fillLine,
  output logic                          memReadReq,
  output logic                          memWriteReq,
  output logic [31:0]                   memAddr,
  output cachePkg::line_t               memWriteLine
);

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    ReadReq,
    WaitFill,
    Done
  } state_t;

  state_t              state;
  state_t              nextState;
  cachePkg::cacheReq_t reqR;
  cachePkg::physAddr_u physAddr;
  logic                fault;

  // Built as page number plus offset, read back as tag, index, offset
  always_comb begin
    physAddr.pageView.ppn     = ppn;
    physAddr.pageView.pageOff = reqR.vaddr[cachePkg::PAGE_BITS-1:0];
  end

  assign vpn     = reqR.vaddr[31:cachePkg::PAGE_BITS];
  assign idx     = physAddr.cacheView.index;
  assign tag     = physAddr.cacheView.tag;
  assign byteOff = physAddr.cacheView.byteOff;
  assign word    = reqR.word;
  assign wdata   = reqR.wdata;

  assign fault = tlbMiss || (reqR.word && byteOff[1:0] != 2'b00); // Word must be 4-aligned

  assign busy = (state != Idle) && (state != Done);
  assign done = (state == Done);
  assign resp = '{loadData: loadData, fault: fault};

  // Stores commit on the edge that ends done
  assign storeWrite = done && reqR.write && !fault;
  assign markDirty  = storeWrite;

  assign lineFill = (state == WaitFill) && memFill;
  assign tagFill  = lineFill;
  assign fillLine = memLine;

  assign memWriteReq  = (state == WriteBack);
  assign memReadReq   = (state == ReadReq);
  assign memWriteLine = line; // Victim still sits at this index
  assign memAddr      = memWriteReq ? {victimTag, idx, {cachePkg::OFF_BITS{1'b0}}}
                                    : {tag, idx, {cachePkg::OFF_BITS{1'b0}}};

  always_comb begin
    nextState = state;
    case (state)
      Idle, Done: nextState = reqStrobe ? Lookup : Idle;
      Lookup: begin
        if (fault || hit) begin
          nextState = Done;
        end else if (dirty) begin
          nextState = WriteBack;
        end else begin
          nextState = ReadReq;
        end
      end
      WriteBack: nextState = ReadReq;
      ReadReq:   nextState = WaitFill;
      WaitFill: begin
        if (memFill) begin
          nextState = Lookup; // Re-check, now a hit
        end
      end
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk) begin
    if (reqStrobe && !busy) begin
      reqR <= req;
    end
  end

endmodule

// ==== design/transBuffer.sv ====
`timescale 1ns/10ps

module transBuffer #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [cachePkg::VPN_BITS-1:0] vpn,
  output logic [cachePkg::PPN_BITS-1:0] ppn,
  output logic                          tlbMiss,
  input  logic                          tlbWrite,
  input  cachePkg::tlbEntry_t           tlbEntry
);

  localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  cachePkg::tlbEntry_t    entries [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid;
  logic [PTR_BITS-1:0]    fillPtr; // Round-robin victim slot

  // Fully associative compare
  always_comb begin
    tlbMiss = 1'b1;
    ppn     = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid[i] && entries[i].vpn == vpn) begin
        tlbMiss = 1'b0;
        ppn     = entries[i].ppn;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid   <= '0;
      fillPtr <= '0;
    end else if (tlbWrite) begin
      valid[fillPtr] <= 1'b1;
      if (fillPtr == PTR_BITS'(TLB_ENTRIES - 1)) begin
        fillPtr <= '0;
      end else begin
        fillPtr <= fillPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      entries[fillPtr] <= tlbEntry;
    end
  end

endmodule

// ==== design/lineStore.sv ====
`timescale 1ns/10ps

module lineStore (
  input  logic                          clk,
  input  logic [cachePkg::IDX_BITS-1:0] idx,
  input  logic [cachePkg::OFF_BITS-1:0] byteOff,
  input  logic                          word,
  input  logic                          write,
  input  logic                          fill,
  input  logic [31:0]                   wdata,
  input  cachePkg::line_t               fillLine,
  output cachePkg::line_t               line,
  output logic [31:0]                   loadData
);

  cachePkg::line_t mem [cachePkg::LINES];

  logic [7:0] b0;
  logic [7:0] b1;
  logic [7:0] b2;
  logic [7:0] b3;

  assign line = mem[idx];

  // Bytes from the offset upward, offset wraps inside the line
  assign b0 = line[byteOff];
  assign b1 = line[byteOff + 3'd1];
  assign b2 = line[byteOff + 3'd2];
  assign b3 = line[byteOff + 3'd3];

  assign loadData = word ? {b3, b2, b1, b0} : {{24{b0[7]}}, b0}; // Sign-extend bytes

  always_ff @(posedge clk) begin
    if (fill) begin
      mem[idx] <= fillLine;
    end else if (write) begin
      for (int k = 0; k < 4; k++) begin
        if (word || k == 0) begin
          mem[idx][byteOff + 3'(k)] <= wdata[8*k +: 8]; // Little-endian
        end
      end
    end
  end

endmodule

// ==== design/tagStore.sv ====
`timescale 1ns/10ps

module tagStore (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [cachePkg::IDX_BITS-1:0] idx,
  input  logic [cachePkg::TAG_BITS-1:0] tag,
  input  logic                          fill,
  input  logic                          markDirty,
  output logic                          hit,
  output logic                          dirty,
  output logic [cachePkg::TAG_BITS-1:0] victimTag
);

  logic [cachePkg::TAG_BITS-1:0] tags [cachePkg::LINES];
  logic [cachePkg::LINES-1:0]    validBits;
  logic [cachePkg::LINES-1:0]    dirtyBits;

  assign victimTag = tags[idx];
  assign hit       = validBits[idx] && (tags[idx] == tag);
  assign dirty     = dirtyBits[idx]; // Only ever set on a valid line

  always_ff @(posedge clk) begin
    if (rst) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (fill) begin
      validBits[idx] <= 1'b1;
      dirtyBits[idx] <= 1'b0; // Fresh line from memory
    end else if (markDirty) begin
      dirtyBits[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[idx] <= tag;
    end
  end

endmodule

// ==== design/cachePkg.sv ====
package cachePkg;

  localparam int LINES      = 32;
  localparam int LINE_BYTES = 8;
  localparam int IDX_BITS   = 5;
  localparam int OFF_BITS   = 3;
  localparam int TAG_BITS   = 24; // Physical address bits 31..8
  localparam int PAGE_BITS  = 12;
  localparam int VPN_BITS   = 20;
  localparam int PPN_BITS   = 20;

  typedef logic [LINE_BYTES-1:0][7:0] line_t; // Byte 0 in the low bits

  typedef struct packed {
    logic [PPN_BITS-1:0]  ppn;
    logic [PAGE_BITS-1:0] pageOff;
  } pageView_t;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] index;
    logic [OFF_BITS-1:0] byteOff;
  } cacheView_t;

  // Same 32-bit physical address seen as page fields or as cache fields
  typedef union packed {
    pageView_t  pageView;
    cacheView_t cacheView;
  } physAddr_u;

  typedef struct packed {
    logic        write; // Store when set
    logic        word;  // 32-bit access when set
    logic [31:0] vaddr;
    logic [31:0] wdata;
  } cacheReq_t;

  typedef struct packed {
    logic [31:0] loadData;
    logic        fault;
  } cacheResp_t;

  typedef struct packed {
    logic [VPN_BITS-1:0] vpn;
    logic [PPN_BITS-1:0] ppn;
  } tlbEntry_t;

endpackage
